// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = uart_tb
FILELIST  = build.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test OK"

clean:
	rm -rf obj_dir

// File: build.f
verilog/uart_reg_pkg.sv
verilog/uart_line_pkg.sv
verilog/uart_fifo.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/uart_regs.sv
verilog/uart.sv
tests/uart_sva.sv
tests/uart_tb.sv

// File: tests/uart_sva.sv
`timescale 1ns/1ps
`default_nettype none

module uart_sva (
  input wire logic clock,
  input wire logic reset,
  input wire logic rd_en,
  input wire logic wr_en,
  input wire logic busy,
  input wire logic txd
);

  logic accepted;

  assign accepted = !busy && (rd_en || wr_en);

  // Two busy cycles per accepted request
  busy_rise: assert property (@(posedge clock) disable iff (reset) accepted |=> busy)
    else $error("busy did not rise after an accepted request");
  busy_second: assert property (@(posedge clock) disable iff (reset)
    (busy && !$past(busy)) |=> busy)
    else $error("busy lasted only one cycle");
  busy_end: assert property (@(posedge clock) disable iff (reset)
    (busy && $past(busy)) |=> !busy)
    else $error("busy lasted more than two cycles");

  busy_after_reset: assert property (@(posedge clock) $fell(reset) |-> !busy)
    else $error("busy high right after reset");
  txd_in_reset: assert property (@(posedge clock) reset |-> txd)
    else $error("txd low during reset");

endmodule

bind uart uart_sva sva (
  .clock(clock), .reset(reset), .rd_en(rd_en), .wr_en(wr_en), .busy(busy), .txd(txd)
);

`default_nettype wire

// File: tests/uart_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tb import uart_reg_pkg::*, uart_line_pkg::*; ();

  // Frames on both lines plus one idle frame after the transmit burst
  localparam int FRAMES         = 21;
  localparam int DIV_MAX        = 15;
  localparam int TIMEOUT_CYCLES = 3 * FRAMES * 11 * (DIV_MAX + 1) + 2000;

  logic              clock;
  logic              reset;
  logic              rd_en;
  logic              wr_en;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wr_data;
  logic [DATA_W-1:0] rd_data;
  logic              busy;
  logic              rxd;
  logic              txd;

  // Reference model
  logic [31:0]       rng;
  logic [BYTE_W-1:0] tx_model[$];
  logic [BYTE_W-1:0] rx_model[$];
  logic [BYTE_W-1:0] tx_seen[$];
  logic              ie_tx;
  logic              ie_rx;
  int                txwm;
  int                rxwm;
  int                mon_p;
  int                mon_nstop;

  uart DUT (
    .clock(clock), .reset(reset), .rd_en(rd_en), .wr_en(wr_en), .addr(addr),
    .wr_data(wr_data), .rd_data(rd_data), .busy(busy), .rxd(rxd), .txd(txd)
  );

  always #50 clock = ~clock;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function logic [31:0] random_word();
    rng = xorshift32(rng);
    return rng;
  endfunction

  task automatic stop_on_failure();
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_byte(input logic [BYTE_W-1:0] got, input logic [BYTE_W-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  // One request followed by the two busy cycles
  task automatic bus_access(input logic write, input logic [2:0] idx,
                            input logic [DATA_W-1:0] data, output logic [DATA_W-1:0] result);
    @(posedge clock);
    rd_en   <= !write;
    wr_en   <= write;
    addr    <= {idx, 2'b00};
    wr_data <= data;
    @(posedge clock);
    rd_en <= 1'b0;
    wr_en <= 1'b0;
    @(negedge clock);
    while (busy) @(negedge clock);
    result = rd_data;
  endtask

  task automatic write_reg(input logic [2:0] idx, input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] ignored;
    bus_access(1'b1, idx, data, ignored);
  endtask

  task automatic read_reg(input logic [2:0] idx, output logic [DATA_W-1:0] result);
    bus_access(1'b0, idx, '0, result);
  endtask

  task automatic readback(input reg_index_e idx, input logic [DATA_W-1:0] mask,
                          input string what);
    logic [DATA_W-1:0] w;
    logic [DATA_W-1:0] r;
    w = random_word();
    write_reg(idx, w);
    read_reg(idx, r);
    check_word(r, w & mask, what);
  endtask

  task automatic check_ip();
    logic [DATA_W-1:0] r;
    logic              exp_tx;
    logic              exp_rx;
    exp_tx = ie_tx && (tx_model.size() < txwm);
    exp_rx = ie_rx && (rx_model.size() > rxwm);
    read_reg(REG_IP, r);
    check_word(r, {30'h0, exp_rx, exp_tx}, "IP");
  endtask

  // 8N1 frame followed by one idle period
  task automatic send_frame(input logic [BYTE_W-1:0] b, input int p);
    logic [9:0] bits;
    bits = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clock);
      rxd <= bits[i];
      repeat (p - 1) @(posedge clock);
    end
    repeat (p) @(posedge clock);
  endtask

  // Decodes txd at bit centres and checks the stop length
  initial begin : txd_monitor
    logic [BYTE_W-1:0] b;
    int                half;
    @(negedge reset);
    forever begin
      @(negedge clock);
      if (txd === 1'b0) begin
        half = mon_p / 2;
        repeat (half) @(negedge clock);
        check_bit(txd, 1'b0, "start bit");
        for (int j = 0; j < BYTE_W; j++) begin
          repeat (mon_p) @(negedge clock);
          b[j] = txd;
        end
        repeat (mon_p - half) @(negedge clock);
        for (int k = 0; k < mon_nstop * mon_p; k++) begin
          check_bit(txd, 1'b1, "stop bit");
          @(negedge clock);
        end
        tx_seen.push_back(b);
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clock);
    $display("Timeout: the run did not finish in %0d clock cycles", TIMEOUT_CYCLES);
    stop_on_failure();
  end

  initial begin : main
    logic [DATA_W-1:0] r;
    logic [DATA_W-1:0] w;
    int                div;
    clock     = 1'b0;
    reset     = 1'b1;
    rd_en     = 1'b0;
    wr_en     = 1'b0;
    addr      = '0;
    wr_data   = '0;
    rxd       = 1'b1;
    rng       = 32'hea282114;
    mon_p     = 1;
    mon_nstop = 1;
    repeat (5) @(posedge clock);
    reset <= 1'b0;

    // Reset values including index 7
    read_reg(REG_TXDATA, r);
    check_word(r, 32'h0, "TXDATA after reset");
    read_reg(REG_RXDATA, r);
    check_word(r, 32'h8000_0000, "RXDATA after reset");
    for (int i = 2; i < 8; i++) begin
      read_reg(3'(i), r);
      check_word(r, (i == int'(REG_DIV)) ? 32'd85 : '0, "value after reset");
    end

    for (int i = 0; i < 3; i++) begin
      readback(REG_TXCTRL, 32'h0007_0003, "TXCTRL readback");
      readback(REG_RXCTRL, 32'h0007_0001, "RXCTRL readback");
      readback(REG_IE, 32'h0000_0003, "IE readback");
      readback(REG_DIV, 32'h0000_ffff, "DIV readback");
    end

    // Fill the transmit FIFO with the transmitter off
    r = random_word();
    ie_tx = r[0];
    ie_rx = r[1];
    write_reg(REG_IE, {30'h0, ie_rx, ie_tx});
    w = random_word() & 32'h0007_0000;
    txwm = int'(w[18:16]);
    write_reg(REG_TXCTRL, w);
    rxwm = 0;
    write_reg(REG_RXCTRL, 32'h0);
    for (int i = 0; i < 10; i++) begin
      r = random_word();
      write_reg(REG_TXDATA, {24'h0, r[7:0]});
      if (tx_model.size() < FIFO_DEPTH) tx_model.push_back(r[7:0]);
      read_reg(REG_TXDATA, r);
      check_word(r, {tx_model.size() == FIFO_DEPTH, 31'h0}, "TXDATA full flag");
      check_ip();
    end

    r = random_word();
    div = 4 + int'(r % 32'd12);
    mon_p = div + 1;
    mon_nstop = r[31] ? 2 : 1;
    write_reg(REG_DIV, 32'(div));
    write_reg(REG_TXCTRL, w | {30'h0, r[31], 1'b1});
    while (tx_seen.size() < FIFO_DEPTH) @(negedge clock);
    // Room for a ninth frame that must not appear
    repeat (12 * mon_p) @(negedge clock);
    check_word(32'(tx_seen.size()), 32'(FIFO_DEPTH), "transmitted frame count");
    foreach (tx_model[i]) check_byte(tx_seen[i], tx_model[i], "transmitted byte");
    tx_model.delete();

    // Receive path with two frames beyond the FIFO depth
    w = (random_word() & 32'h0007_0000) | 32'h1;
    rxwm = int'(w[18:16]);
    write_reg(REG_RXCTRL, w);
    for (int i = 0; i < 10; i++) begin
      r = random_word();
      send_frame(r[7:0], mon_p);
      if (rx_model.size() < FIFO_DEPTH) rx_model.push_back(r[7:0]);
      check_ip();
    end
    while (rx_model.size() > 0) begin
      read_reg(REG_RXDATA, r);
      check_bit(r[31], 1'b0, "RXDATA empty flag");
      check_byte(r[7:0], rx_model.pop_front(), "received byte");
      check_ip();
    end
    read_reg(REG_RXDATA, r);
    check_word(r, 32'h8000_0000, "RXDATA after drain");

    write_reg(REG_RXCTRL, w & ~32'h1);
    repeat (2) begin
      r = random_word();
      send_frame(r[7:0], mon_p);
    end
    write_reg(REG_RXCTRL, w);
    read_reg(REG_RXDATA, r);
    check_word(r, 32'h8000_0000, "RXDATA with receiver off");

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/uart.sv
`timescale 1ns/1ps
`default_nettype none

module uart import uart_reg_pkg::*, uart_line_pkg::*; (
  input  wire logic              clock,
  input  wire logic              reset,
  input  wire logic              rd_en,
  input  wire logic              wr_en,
  input  wire logic [ADDR_W-1:0] addr,
  input  wire logic [DATA_W-1:0] wr_data,
  output logic      [DATA_W-1:0] rd_data,
  output logic                   busy,
  input  wire logic              rxd,
  output logic                   txd
);

  logic               tx_push;
  logic [BYTE_W-1:0]  tx_push_data;
  logic [BYTE_W-1:0]  tx_head;
  logic [COUNT_W-1:0] tx_count;
  logic               tx_full;
  logic               tx_empty;
  logic               tx_take;
  logic               rx_pop;
  logic [BYTE_W-1:0]  rx_head;
  logic [COUNT_W-1:0] rx_count;
  logic               rx_empty;
  logic               rx_strobe;
  logic [BYTE_W-1:0]  rx_byte;
  logic               tx_enable;
  logic               two_stop;
  logic               rx_enable;
  logic [DIV_W-1:0]   divisor;

  uart_regs regs (
    .clock(clock), .reset(reset), .rd_en(rd_en), .wr_en(wr_en), .addr(addr),
    .wr_data(wr_data), .rd_data(rd_data), .busy(busy),
    .tx_push(tx_push), .tx_push_data(tx_push_data), .tx_count(tx_count), .tx_full(tx_full),
    .rx_pop(rx_pop), .rx_head(rx_head), .rx_count(rx_count), .rx_empty(rx_empty),
    .tx_enable(tx_enable), .two_stop(two_stop), .rx_enable(rx_enable), .divisor(divisor)
  );

  uart_fifo tx_fifo (
    .clock(clock), .reset(reset), .push(tx_push), .pop(tx_take),
    .push_data(tx_push_data), .pop_data(tx_head), .count(tx_count),
    .full(tx_full), .empty(tx_empty)
  );

  // Received bytes are lost inside the FIFO when it is full
  uart_fifo rx_fifo (
    .clock(clock), .reset(reset), .push(rx_strobe), .pop(rx_pop),
    .push_data(rx_byte), .pop_data(rx_head), .count(rx_count),
    .full(), .empty(rx_empty)
  );

  uart_tx tx (
    .clock(clock), .reset(reset), .enable(tx_enable), .two_stop(two_stop),
    .divisor(divisor), .data(tx_head), .valid(!tx_empty), .take(tx_take), .txd(txd)
  );

  uart_rx rx (
    .clock(clock), .reset(reset), .enable(rx_enable), .divisor(divisor),
    .rxd(rxd), .data(rx_byte), .strobe(rx_strobe)
  );

endmodule

`default_nettype wire

// File: verilog/uart_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module uart_fifo import uart_line_pkg::*; (
  input  wire logic               clock,
  input  wire logic               reset,
  input  wire logic               push,
  input  wire logic               pop,
  input  wire logic [BYTE_W-1:0]  push_data,
  output logic      [BYTE_W-1:0]  pop_data,
  output logic      [COUNT_W-1:0] count,
  output logic                    full,
  output logic                    empty
);

  logic [BYTE_W-1:0]             mem [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
  logic                          do_push;
  logic                          do_pop;

  // Push when full and pop when empty are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign full     = (count == COUNT_W'(FIFO_DEPTH));
  assign empty    = (count == '0);
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap naturally at the power-of-two depth
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/uart_line_pkg.sv
`default_nettype none

// Serial line, FIFO and baud definitions
package uart_line_pkg;

  // Frame payload and FIFO sizing
  localparam int BYTE_W     = 8;
  localparam int FIFO_DEPTH = 8;
  localparam int COUNT_W    = 4;
  localparam int WM_W       = 3;

  // One bit period is divisor + 1 clocks
  localparam int DIV_W     = 16;
  localparam int CLOCK_HZ  = 10_000_000;
  localparam int BAUD_RATE = 115_200;
  localparam int DIV_RESET = CLOCK_HZ / BAUD_RATE - 1;

  typedef enum logic [1:0] {
    TX_IDLE  = 2'd0,
    TX_START = 2'd1,
    TX_DATA  = 2'd2,
    TX_STOP  = 2'd3
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE  = 2'd0,
    RX_START = 2'd1,
    RX_DATA  = 2'd2,
    RX_STOP  = 2'd3
  } rx_state_e;

endpackage

`default_nettype wire

// File: verilog/uart_reg_pkg.sv
`default_nettype none

// Register map and bus handshake definitions
package uart_reg_pkg;

  // Bus widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 5;

  // Word index taken from addr[4:2]; index 7 is unmapped and reads zero
  typedef enum logic [2:0] {
    REG_TXDATA = 3'd0,
    REG_RXDATA = 3'd1,
    REG_TXCTRL = 3'd2,
    REG_RXCTRL = 3'd3,
    REG_IE     = 3'd4,
    REG_IP     = 3'd5,
    REG_DIV    = 3'd6
  } reg_index_e;

  // Two busy cycles per access
  typedef enum logic [1:0] {
    BUS_IDLE  = 2'd0,
    BUS_READ  = 2'd1,
    BUS_WRITE = 2'd2,
    BUS_NOP   = 2'd3
  } bus_state_e;

endpackage

`default_nettype wire

// File: verilog/uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_regs import uart_reg_pkg::*, uart_line_pkg::*; (
  input  wire logic               clock,
  input  wire logic               reset,
  input  wire logic               rd_en,
  input  wire logic               wr_en,
  input  wire logic [ADDR_W-1:0]  addr,
  input  wire logic [DATA_W-1:0]  wr_data,
  output logic      [DATA_W-1:0]  rd_data,
  output logic                    busy,
  output logic                    tx_push,
  output logic      [BYTE_W-1:0]  tx_push_data,
  input  wire logic [COUNT_W-1:0] tx_count,
  input  wire logic               tx_full,
  output logic                    rx_pop,
  input  wire logic [BYTE_W-1:0]  rx_head,
  input  wire logic [COUNT_W-1:0] rx_count,
  input  wire logic               rx_empty,
  output logic                    tx_enable,
  output logic                    two_stop,
  output logic                    rx_enable,
  output logic      [DIV_W-1:0]   divisor
);

  bus_state_e        state;
  reg_index_e        req_index;
  logic [DATA_W-1:0] req_data;
  logic [DATA_W-1:0] read_word;
  logic [WM_W-1:0]   tx_wm;
  logic [WM_W-1:0]   rx_wm;
  logic              ie_txwm;
  logic              ie_rxwm;
  logic              ip_txwm;
  logic              ip_rxwm;
  logic              wr_cycle;

  assign busy     = (state != BUS_IDLE);
  assign wr_cycle = (state == BUS_WRITE);

  // FIFO strobes fire in the access cycle
  assign tx_push      = wr_cycle && (req_index == REG_TXDATA);
  assign rx_pop       = (state == BUS_READ) && (req_index == REG_RXDATA);
  assign tx_push_data = req_data[BYTE_W-1:0];

  // Request is captured on acceptance so the host may drop it afterwards
  always_ff @(posedge clock) begin
    if (state == BUS_IDLE && (rd_en || wr_en)) begin
      req_index <= reg_index_e'(addr[4:2]);
      req_data  <= wr_data;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= BUS_IDLE;
    end else begin
      case (state)
        BUS_IDLE: begin
          if (rd_en) begin
            state <= BUS_READ;
          end else if (wr_en) begin
            state <= BUS_WRITE;
          end
        end
        BUS_READ:  state <= BUS_NOP;
        BUS_WRITE: state <= BUS_NOP;
        default:   state <= BUS_IDLE;
      endcase
    end
  end

  always_comb begin
    read_word = '0;
    case (req_index)
      REG_TXDATA: read_word[31] = tx_full;
      REG_RXDATA: begin
        read_word[31] = rx_empty;
        read_word[BYTE_W-1:0] = rx_empty ? '0 : rx_head;
      end
      REG_TXCTRL: begin
        read_word[0]     = tx_enable;
        read_word[1]     = two_stop;
        read_word[18:16] = tx_wm;
      end
      REG_RXCTRL: begin
        read_word[0]     = rx_enable;
        read_word[18:16] = rx_wm;
      end
      REG_IE:  read_word[1:0] = {ie_rxwm, ie_txwm};
      REG_IP:  read_word[1:0] = {ip_rxwm, ip_txwm};
      REG_DIV: read_word[DIV_W-1:0] = divisor;
      default: read_word = '0;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rd_data   <= '0;
      tx_enable <= 1'b0;
      two_stop  <= 1'b0;
      tx_wm     <= '0;
      rx_enable <= 1'b0;
      rx_wm     <= '0;
      ie_txwm   <= 1'b0;
      ie_rxwm   <= 1'b0;
      ip_txwm   <= 1'b0;
      ip_rxwm   <= 1'b0;
      divisor   <= DIV_W'(DIV_RESET);
    end else begin
      if (state == BUS_READ) begin
        rd_data <= read_word;
      end
      if (wr_cycle && req_index == REG_TXCTRL) begin
        tx_enable <= req_data[0];
        two_stop  <= req_data[1];
        tx_wm     <= req_data[18:16];
      end
      if (wr_cycle && req_index == REG_RXCTRL) begin
        rx_enable <= req_data[0];
        rx_wm     <= req_data[18:16];
      end
      if (wr_cycle && req_index == REG_IE) begin
        ie_txwm <= req_data[0];
        ie_rxwm <= req_data[1];
      end
      if (wr_cycle && req_index == REG_DIV) begin
        divisor <= req_data[DIV_W-1:0];
      end
      // Watermark pending bits lag the counts by one cycle
      ip_txwm <= ie_txwm && (tx_count < COUNT_W'(tx_wm));
      ip_rxwm <= ie_rxwm && (rx_count > COUNT_W'(rx_wm));
    end
  end

endmodule

`default_nettype wire

// File: verilog/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_line_pkg::*; (
  input  wire logic              clock,
  input  wire logic              reset,
  input  wire logic              enable,
  input  wire logic [DIV_W-1:0]  divisor,
  input  wire logic              rxd,
  output logic      [BYTE_W-1:0] data,
  output logic                   strobe
);

  rx_state_e                 state;
  logic                      rxd_meta;
  logic                      rxd_sync;
  logic                      rxd_prev;
  logic [DIV_W-1:0]          cnt;
  logic [DIV_W-1:0]          div_q;
  logic [$clog2(BYTE_W)-1:0] bit_idx;

  // Two-flop synchronizer plus one flop for edge detection
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  // Divisor is sampled at the falling edge of the start bit
  always_ff @(posedge clock) begin
    if (state == RX_IDLE && rxd_prev && !rxd_sync) begin
      div_q <= divisor;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state   <= RX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      data    <= '0;
      strobe  <= 1'b0;
    end else begin
      strobe <= 1'b0;
      cnt    <= cnt + 1'b1;
      if (!enable) begin
        state <= RX_IDLE;
      end else begin
        case (state)
          RX_IDLE: begin
            cnt <= '0;
            if (rxd_prev && !rxd_sync) begin
              state <= RX_START;
            end
          end
          RX_START: begin
            // Re-check the start bit at its centre
            if (cnt == (div_q >> 1)) begin
              cnt     <= '0;
              bit_idx <= '0;
              state   <= rxd_sync ? RX_IDLE : RX_DATA;
            end
          end
          RX_DATA: begin
            if (cnt == div_q) begin
              cnt     <= '0;
              data    <= {rxd_sync, data[BYTE_W-1:1]};
              bit_idx <= bit_idx + 1'b1;
              if (&bit_idx) begin
                state <= RX_STOP;
              end
            end
          end
          RX_STOP: begin
            if (cnt == div_q) begin
              // A low stop bit drops the frame
              strobe <= rxd_sync;
              state  <= RX_IDLE;
            end
          end
          default: state <= RX_IDLE;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_line_pkg::*; (
  input  wire logic              clock,
  input  wire logic              reset,
  input  wire logic              enable,
  input  wire logic              two_stop,
  input  wire logic [DIV_W-1:0]  divisor,
  input  wire logic [BYTE_W-1:0] data,
  input  wire logic              valid,
  output logic                   take,
  output logic                   txd
);

  tx_state_e                 state;
  logic [DIV_W-1:0]          cnt;
  logic [DIV_W-1:0]          div_q;
  logic [BYTE_W-1:0]         shift;
  logic [$clog2(BYTE_W)-1:0] bit_idx;
  logic                      stop_more;

  // Pop the FIFO head in the same cycle it is latched
  assign take = (state == TX_IDLE) && enable && valid;

  // Frame settings travel with the byte
  always_ff @(posedge clock) begin
    if (take) begin
      div_q     <= divisor;
      stop_more <= two_stop;
      shift     <= data;
    end else if (state != TX_IDLE && cnt == div_q) begin
      if (state == TX_START || state == TX_DATA) begin
        shift <= shift >> 1;
      end
      if (state == TX_STOP) begin
        stop_more <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state   <= TX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      txd     <= 1'b1;
    end else begin
      cnt <= cnt + 1'b1;
      case (state)
        TX_IDLE: begin
          cnt <= '0;
          txd <= !take;
          if (take) begin
            state <= TX_START;
          end
        end
        TX_START: begin
          if (cnt == div_q) begin
            cnt     <= '0;
            bit_idx <= '0;
            txd     <= shift[0];
            state   <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (cnt == div_q) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            txd     <= (&bit_idx) ? 1'b1 : shift[0];
            if (&bit_idx) begin
              state <= TX_STOP;
            end
          end
        end
        TX_STOP: begin
          if (cnt == div_q) begin
            cnt <= '0;
            // Second stop period when enabled
            if (!stop_more) begin
              state <= TX_IDLE;
            end
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire
